//--- design/credit_fifo.sv
`default_nettype none

module credit_fifo #(
    parameter type PAYLOAD_T = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  PAYLOAD_T push_data,
    input  logic     pop_en,
    output PAYLOAD_T head,
    output logic     head_valid,
    output logic     credit_return
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    PAYLOAD_T         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    // wrap explicitly so depths that are not a power of two work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

    // retire the head unless the pipeline holds us
    assign pop           = head_valid && pop_en;
    // one credit back per retired entry, same cycle
    assign credit_return = pop;

    // payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers and occupancy
    // sender never pushes without a credit, so no full check here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/gpr_array.sv
`include "regfile_consts.svh"

`default_nettype none

module gpr_array (
    input  logic                   clk,
    input  logic                   rst_n,
    input  regfile_pkg::byte_en_t  byte_en,
    input  regfile_pkg::reg_data_t lane_data,
    output regfile_pkg::reg_data_t regs [`RF_NUM_REGS]
);

    // one block per register
    // reg 0 is eax, then ecx, edx, ebx, esp, ebp, esi, edi
    for (genvar r = 0; r < `RF_NUM_REGS; r++) begin : g_reg

        // each byte lane has its own enable
        // the decoder already placed the right byte on every lane
        for (genvar b = 0; b < `RF_LANES; b++) begin : g_lane

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    // architectural state reads zero out of reset
                    regs[r][8*b +: 8] <= 8'h00;
                end else if (byte_en[r][b]) begin
                    regs[r][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end

        end

    end

endmodule

`default_nettype wire

//--- design/read_aligner.sv
`include "regfile_consts.svh"

`default_nettype none

module read_aligner (
    input  regfile_pkg::rd_req_t   req,
    input  regfile_pkg::reg_data_t regs [`RF_NUM_REGS],
    output regfile_pkg::reg_data_t data
);

    import regfile_pkg::*;

    // register selected by the full id, for 16 and 32 bit reads
    reg_data_t sel_reg;
    // register selected by id[1:0], for byte reads
    reg_data_t byte_src;

    assign sel_reg  = regs[req.id];
    assign byte_src = regs[{1'b0, req.id[1:0]}];

    // same aliasing as the write side, result zero-extended
    always_comb begin
        case (req.size)
            SIZE_32: data = sel_reg;
            SIZE_16: data = reg_data_t'(sel_reg[15:0]);
            SIZE_8: begin
                // ah/ch/dh/bh come from bits 15:8 of id-4
                if (req.id[2]) begin
                    data = reg_data_t'(byte_src[15:8]);
                end else begin
                    data = reg_data_t'(byte_src[7:0]);
                end
            end
            // reserved size reads as zero
            default: data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/regfile_pkg.sv
`include "regfile_consts.svh"

`default_nettype none

package regfile_pkg;

    // register number as it appears in the instruction encoding
    typedef logic [$clog2(`RF_NUM_REGS)-1:0] reg_id_t;

    // operand size code, same encoding as the decode stage
    typedef enum logic [1:0] {
        SIZE_8    = 2'd0,
        SIZE_16   = 2'd1,
        SIZE_32   = 2'd2,
        SIZE_RSVD = 2'd3
    } op_size_t;

    // one full register value
    typedef logic [`RF_DATA_W-1:0] reg_data_t;

    // a single writeback from the pipeline
    // for 8/16 bit sizes only the low bits of data matter
    typedef struct packed {
        reg_id_t   id;
        op_size_t  size;
        reg_data_t data;
    } wr_req_t;

    // byte enables, outer index is the register, inner is the byte lane
    typedef logic [`RF_NUM_REGS-1:0][`RF_LANES-1:0] byte_en_t;

    // read port request
    // id 4..7 at byte size means the high byte of id-4 (ah, ch, dh, bh)
    typedef struct packed {
        reg_id_t  id;
        op_size_t size;
    } rd_req_t;

endpackage

`default_nettype wire

//--- design/regfile_top.sv
`include "regfile_consts.svh"

`default_nettype none

module regfile_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_valid,
    input  regfile_pkg::wr_req_t   wr_req,
    output logic                   credit_return,
    input  logic                   wb_stall,
    input  regfile_pkg::rd_req_t   rd0_req,
    output regfile_pkg::reg_data_t rd0_data,
    input  regfile_pkg::rd_req_t   rd1_req,
    output regfile_pkg::reg_data_t rd1_data
);

    import regfile_pkg::*;

    wr_req_t   head;
    logic      head_valid;
    logic      pop_en;
    logic      retire;
    byte_en_t  byte_en;
    reg_data_t lane_data;
    reg_data_t regs [`RF_NUM_REGS];

    // stall from the pipeline holds the queue head
    assign pop_en = !wb_stall;
    // head is written only in the cycle it leaves the queue
    assign retire = head_valid && pop_en;

    credit_fifo #(
        .PAYLOAD_T (wr_req_t),
        .DEPTH     (`RF_FIFO_DEPTH)
    ) fifo_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (wr_valid),
        .push_data     (wr_req),
        .pop_en        (pop_en),
        .head          (head),
        .head_valid    (head_valid),
        .credit_return (credit_return)
    );

    write_lane_decoder decoder_inst (
        .req       (head),
        .valid     (retire),
        .byte_en   (byte_en),
        .lane_data (lane_data)
    );

    gpr_array array_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .byte_en   (byte_en),
        .lane_data (lane_data),
        .regs      (regs)
    );

    // two independent combinational read ports
    read_aligner rd0_aligner_inst (
        .req  (rd0_req),
        .regs (regs),
        .data (rd0_data)
    );

    read_aligner rd1_aligner_inst (
        .req  (rd1_req),
        .regs (regs),
        .data (rd1_data)
    );

endmodule

`default_nettype wire

//--- design/write_lane_decoder.sv
`default_nettype none

module write_lane_decoder (
    input  regfile_pkg::wr_req_t   req,
    input  logic                   valid,
    output regfile_pkg::byte_en_t  byte_en,
    output regfile_pkg::reg_data_t lane_data
);

    import regfile_pkg::*;

    // byte writes address only the first four registers
    logic [1:0] byte_reg;
    // id bit 2 selects the high byte (ah/ch/dh/bh) at byte size
    logic       high_byte;

    assign byte_reg  = req.id[1:0];
    assign high_byte = req.id[2];

    // enable matrix
    // 32-bit: all four lanes of reg id
    // 16-bit: lanes 1:0 of reg id
    // 8-bit:  lane 0 of reg id, or lane 1 of reg id-4
    always_comb begin
        byte_en = '0;
        if (valid) begin
            case (req.size)
                SIZE_32: byte_en[req.id] = 4'b1111;
                SIZE_16: byte_en[req.id] = 4'b0011;
                SIZE_8: begin
                    if (high_byte) begin
                        byte_en[{1'b0, byte_reg}] = 4'b0010;
                    end else begin
                        byte_en[{1'b0, byte_reg}] = 4'b0001;
                    end
                end
                // reserved size, nothing gets written
                default: byte_en = '0;
            endcase
        end
    end

    // steer data so every enabled lane sees its byte
    // byte value lands on both lane 0 and lane 1, halfword on both halves
    always_comb begin
        case (req.size)
            SIZE_8:  lane_data = {4{req.data[7:0]}};
            SIZE_16: lane_data = {2{req.data[15:0]}};
            default: lane_data = req.data;
        endcase
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
design/regfile_pkg.sv
design/write_lane_decoder.sv
design/credit_fifo.sv
design/gpr_array.sv
design/read_aligner.sv
design/regfile_top.sv
verif/regfile_sva.sv
verif/regfile_tb.sv

//--- include/regfile_consts.svh
`ifndef REGFILE_CONSTS_SVH
`define REGFILE_CONSTS_SVH

// general registers of the core, eax through edi
`define RF_NUM_REGS 8

// architectural register width in bits
`define RF_DATA_W 32

// bytes per register, one write-enable lane each
`define RF_LANES (`RF_DATA_W / 8)

// writeback queue entries
// the sender owns this many credits coming out of reset
`define RF_FIFO_DEPTH 4

`endif

//--- run.sh
#!/bin/sh
# build and run the register file testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module regfile_tb -Mdir obj_dir

# the simulator exits non-zero on a fatal check, the log carries the verdict
./obj_dir/Vregfile_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1

//--- verif/regfile_sva.sv
`include "regfile_consts.svh"

`default_nettype none

module regfile_sva (
    input logic clk,
    input logic rst_n,
    input logic wr_valid,
    input logic credit_return
);

    timeunit 1ns;
    timeprecision 1ps;

    // queue occupancy rebuilt from the handshake alone
    int occupancy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(wr_valid) - int'(credit_return);
        end
    end

    // sender needs a credit, so a full queue never sees a request
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (occupancy == `RF_FIFO_DEPTH) |-> !wr_valid)
        else $error("write request while the writeback queue is full");

    // a credit only comes back for an entry that was queued
    no_credit_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (occupancy == 0) |-> !credit_return)
        else $error("credit returned from an empty writeback queue");

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !credit_return)
        else $error("credit returned in the first cycle after reset");

endmodule

bind regfile_top regfile_sva regfile_sva_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid      (wr_valid),
    .credit_return (credit_return)
);

`default_nettype wire

//--- verif/regfile_tb.sv
`include "regfile_consts.svh"

`default_nettype none

module regfile_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import regfile_pkg::*;

    localparam int RAND_OPS    = 150;
    // reset plus each test's cycle budget in run order
    localparam int TEST_CYCLES = 5 + 32 + 24 + 12 + 26 + 24 + RAND_OPS + 20;
    // 8 ns per cycle with double headroom and some slack
    localparam int WATCHDOG_NS = TEST_CYCLES * 8 * 2 + 500;

    logic        clk;
    logic        rst_n;
    logic        wr_valid;
    wr_req_t     wr_req;
    logic        credit_return;
    logic        wb_stall;
    rd_req_t     rd0_req;
    rd_req_t     rd1_req;
    reg_data_t   rd0_data;
    reg_data_t   rd1_data;

    // reference model and sender state
    reg_data_t   model [`RF_NUM_REGS];
    wr_req_t     pending [$];
    int          credits;
    int          returns;
    logic [31:0] rng_state;

    regfile_top regfile_top_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic wr_req_t make_wr(input reg_id_t id, input op_size_t size,
                                        input reg_data_t data);
        wr_req_t w;
        w.id   = id;
        w.size = size;
        w.data = data;
        return w;
    endfunction

    function automatic rd_req_t make_rd(input reg_id_t id, input op_size_t size);
        rd_req_t r;
        r.id   = id;
        r.size = size;
        return r;
    endfunction

    // byte writes to ids 4..7 hit bits 15:8 of id-4
    function automatic void apply_write(input wr_req_t w);
        case (w.size)
            SIZE_32: model[w.id] = w.data;
            SIZE_16: model[w.id][15:0] = w.data[15:0];
            SIZE_8: begin
                if (w.id < 3'd4) begin
                    model[w.id][7:0] = w.data[7:0];
                end else begin
                    model[w.id - 3'd4][15:8] = w.data[7:0];
                end
            end
            default: ;
        endcase
    endfunction

    // zero-extended read of the model where a reserved size gives zero
    function automatic reg_data_t expect_read(input rd_req_t r);
        reg_data_t e;
        e = '0;
        case (r.size)
            SIZE_32: e = model[r.id];
            SIZE_16: e = {16'h0, model[r.id][15:0]};
            SIZE_8: begin
                if (r.id < 3'd4) begin
                    e = {24'h0, model[r.id][7:0]};
                end else begin
                    e = {24'h0, model[r.id - 3'd4][15:8]};
                end
            end
            default: e = '0;
        endcase
        return e;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_credit(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("ERR %s got %0h expected %0h", name, got, exp));
        end
    endtask

    // drive both ports and sample inside the low phase
    // returns on the next falling edge
    task automatic read_both(input rd_req_t a, input rd_req_t b);
        rd0_req = a;
        rd1_req = b;
        #1;
        check_data("rd0_data", rd0_data, expect_read(a));
        check_data("rd1_data", rd1_data, expect_read(b));
        @(negedge clk);
    endtask

    // one request per cycle once a credit is held
    task automatic send(input wr_req_t w);
        while (credits == 0) begin
            wr_valid = 1'b0;
            @(negedge clk);
        end
        wr_valid = 1'b1;
        wr_req   = w;
        credits--;
        pending.push_back(w);
        @(negedge clk);
        wr_valid = 1'b0;
    endtask

    task automatic drain();
        while (pending.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // each credit pulse retires one write in the model
    always @(posedge clk) begin
        if (rst_n && credit_return) begin
            if (pending.size() == 0) begin
                stop_on_error("credit_return pulsed with no write outstanding");
            end else begin
                apply_write(pending.pop_front());
                credits++;
                returns++;
            end
        end
    end

    task automatic test_reset_state();
        for (int i = 0; i < `RF_NUM_REGS; i++) begin
            for (int s = 0; s < 4; s++) begin
                read_both(make_rd(reg_id_t'(i), op_size_t'(s)),
                          make_rd(reg_id_t'(7 - i), op_size_t'(s)));
            end
        end
    endtask

    task automatic test_full_writes();
        reg_data_t v;
        for (int i = 0; i < `RF_NUM_REGS; i++) begin
            v = next_random();
            send(make_wr(reg_id_t'(i), SIZE_32, v));
            // after one edge the entry is still queued and the old value shows
            read_both(make_rd(reg_id_t'(i), SIZE_32), make_rd(reg_id_t'(i), SIZE_32));
            // second edge retired it
            rd0_req = make_rd(reg_id_t'(i), SIZE_32);
            #1;
            check_data("rd0_data", rd0_data, v);
            @(negedge clk);
        end
    endtask

    task automatic test_half_write();
        reg_data_t hi;
        reg_data_t lo;
        hi = next_random();
        lo = next_random();
        send(make_wr(3'd2, SIZE_32, hi));
        send(make_wr(3'd2, SIZE_16, lo));
        drain();
        rd0_req = make_rd(3'd2, SIZE_32);
        #1;
        check_data("rd0_data", rd0_data, {hi[31:16], lo[15:0]});
        @(negedge clk);
        read_both(make_rd(3'd2, SIZE_16), make_rd(3'd2, SIZE_32));
    endtask

    task automatic test_byte_writes();
        for (int i = 0; i < `RF_NUM_REGS; i++) begin
            send(make_wr(reg_id_t'(i), SIZE_8, next_random()));
        end
        drain();
        // low byte on one port and its aliased high byte on the other
        for (int i = 0; i < `RF_NUM_REGS; i++) begin
            read_both(make_rd(reg_id_t'(i), SIZE_8), make_rd(reg_id_t'(i ^ 4), SIZE_8));
        end
        for (int i = 0; i < 4; i++) begin
            read_both(make_rd(reg_id_t'(i), SIZE_32), make_rd(reg_id_t'(i + 4), SIZE_32));
        end
    endtask

    task automatic test_stall();
        int        base;
        reg_data_t last;
        base     = returns;
        last     = next_random();
        wb_stall = 1'b1;
        send(make_wr(3'd1, SIZE_32, next_random()));
        send(make_wr(3'd5, SIZE_16, next_random()));
        send(make_wr(3'd1, SIZE_32, last));
        send(make_wr(3'd6, SIZE_8, next_random()));
        repeat (4) @(negedge clk);
        check_credit("sender credits", credits, 0);
        check_credit("credit_return pulses", returns - base, 0);
        read_both(make_rd(3'd1, SIZE_32), make_rd(3'd5, SIZE_32));
        wb_stall = 1'b0;
        // an unstalled full queue retires one entry per edge
        repeat (4) @(negedge clk);
        check_credit("credit_return pulses", returns - base, 4);
        // later write to reg 1 wins
        rd0_req = make_rd(3'd1, SIZE_32);
        #1;
        check_data("rd0_data", rd0_data, last);
        @(negedge clk);
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        for (int n = 0; n < RAND_OPS; n++) begin
            r        = next_random();
            wb_stall = (r[3:0] < 4'd4);
            if (credits > 0 && r[4]) begin
                wr_valid = 1'b1;
                wr_req   = make_wr(reg_id_t'(r[7:5]), op_size_t'(r[9:8]), next_random());
                credits--;
                pending.push_back(wr_req);
            end else begin
                wr_valid = 1'b0;
            end
            read_both(make_rd(reg_id_t'(r[12:10]), op_size_t'(r[14:13])),
                      make_rd(reg_id_t'(r[17:15]), op_size_t'(r[19:18])));
        end
        wr_valid = 1'b0;
        wb_stall = 1'b0;
        drain();
        for (int i = 0; i < `RF_NUM_REGS; i++) begin
            read_both(make_rd(reg_id_t'(i), SIZE_32), make_rd(reg_id_t'(i), SIZE_16));
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        wr_valid  = 1'b0;
        wr_req    = '0;
        wb_stall  = 1'b0;
        rd0_req   = '0;
        rd1_req   = '0;
        credits   = `RF_FIFO_DEPTH;
        returns   = 0;
        rng_state = 32'h15df_f870;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_full_writes();
        test_half_write();
        test_byte_writes();
        test_stall();
        test_random_mix();
        $display("Simulation passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire
